// ==== compile.f ====
+incdir+design
design/rv_csr_pkg.sv
design/csr_addr_decode.sv
design/csr_file.sv
design/clint.sv
design/csr_subsys.sv
test/tb_clk_gen.sv
test/tb_csr_subsys.sv

// ==== design/clint.sv ====
// Core-local interruptor on an APB slave port without wait states.
// Holds msip, mtimecmp and a free-running 64-bit mtime counter, all
// reachable as 32-bit halves. mtip is high while mtime >= mtimecmp.
// Writes land at the edge ending the access cycle; read data and
// pslverr are combinational during the access cycle.
`include "rv_csr_consts.svh"

module clint (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_csr_pkg::apb_req_t apb_req,
    output rv_csr_pkg::apb_rsp_t apb_rsp,
    output logic                 msip,
    output logic                 mtip
);

    logic        access;
    logic        wr;
    logic        sel_msip;
    logic        sel_cmp_lo;
    logic        sel_cmp_hi;
    logic        sel_time_lo;
    logic        sel_time_hi;
    logic        mapped;
    logic [31:0] rdata;

    logic        msip_q;
    logic [63:0] mtimecmp_q;
    logic [63:0] mtime_q;

    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;

    // Offset decode.
    assign sel_msip    = (apb_req.paddr == `CLINT_MSIP);
    assign sel_cmp_lo  = (apb_req.paddr == `CLINT_MTIMECMP_LO);
    assign sel_cmp_hi  = (apb_req.paddr == `CLINT_MTIMECMP_HI);
    assign sel_time_lo = (apb_req.paddr == `CLINT_MTIME_LO);
    assign sel_time_hi = (apb_req.paddr == `CLINT_MTIME_HI);
    assign mapped      = sel_msip | sel_cmp_lo | sel_cmp_hi | sel_time_lo | sel_time_hi;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            msip_q <= 1'b0;
        end else if (wr && sel_msip) begin
            msip_q <= apb_req.pwdata[0];   // Upper bits are not kept.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp_q <= '1;              // Far future, no timer interrupt.
        end else if (wr && sel_cmp_lo) begin
            mtimecmp_q[31:0] <= apb_req.pwdata;
        end else if (wr && sel_cmp_hi) begin
            mtimecmp_q[63:32] <= apb_req.pwdata;
        end
    end

    // A write to one half loads it; otherwise count every edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime_q <= 64'd0;
        end else if (wr && sel_time_lo) begin
            mtime_q <= {mtime_q[63:32], apb_req.pwdata};
        end else if (wr && sel_time_hi) begin
            mtime_q <= {apb_req.pwdata, mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_comb begin
        rdata = 32'd0;
        if (sel_msip) begin
            rdata = {31'd0, msip_q};
        end else if (sel_cmp_lo) begin
            rdata = mtimecmp_q[31:0];
        end else if (sel_cmp_hi) begin
            rdata = mtimecmp_q[63:32];
        end else if (sel_time_lo) begin
            rdata = mtime_q[31:0];
        end else if (sel_time_hi) begin
            rdata = mtime_q[63:32];
        end
    end

    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : 32'd0;
    assign apb_rsp.pready  = 1'b1;                 // No wait states.
    assign apb_rsp.pslverr = access & ~mapped;

    assign msip = msip_q;
    assign mtip = (mtime_q >= mtimecmp_q);

    // Access phase only inside a selected transfer.
    a_penable_needs_psel : assert property (
        @(posedge clk) disable iff (!arst_n)
        apb_req.penable |-> apb_req.psel
    );

    // An erroring access leaves msip and mtimecmp alone.
    a_err_no_write : assert property (
        @(posedge clk) disable iff (!arst_n)
        apb_rsp.pslverr |=> ($stable(msip_q) && $stable(mtimecmp_q))
    );

endmodule

// ==== design/csr_addr_decode.sv ====
// Maps a 12-bit machine CSR address to its index in the register array.
// hit is low for unmapped addresses or when en is low; idx is 0 then.
// Used twice by the CSR file, once per read and once per write address.
`include "rv_csr_consts.svh"

module csr_addr_decode (
    input  logic [11:0]         addr,
    input  logic                en,
    output rv_csr_pkg::csr_idx_t idx,
    output logic                hit
);

    always_comb begin
        idx = '0;
        hit = 1'b0;
        if (en) begin
            hit = 1'b1;
            case (addr)
                `CSR_ADDR_MSTATUS:    idx = `CSR_IDX_MSTATUS;
                `CSR_ADDR_MISA:       idx = `CSR_IDX_MISA;
                `CSR_ADDR_MEDELEG:    idx = `CSR_IDX_MEDELEG;
                `CSR_ADDR_MIDELEG:    idx = `CSR_IDX_MIDELEG;
                `CSR_ADDR_MIE:        idx = `CSR_IDX_MIE;
                `CSR_ADDR_MTVEC:      idx = `CSR_IDX_MTVEC;
                `CSR_ADDR_MCOUNTEREN: idx = `CSR_IDX_MCOUNTEREN;
                `CSR_ADDR_MSTATUSH:   idx = `CSR_IDX_MSTATUSH;
                `CSR_ADDR_MSCRATCH:   idx = `CSR_IDX_MSCRATCH;
                `CSR_ADDR_MEPC:       idx = `CSR_IDX_MEPC;
                `CSR_ADDR_MCAUSE:     idx = `CSR_IDX_MCAUSE;
                `CSR_ADDR_MTVAL:      idx = `CSR_IDX_MTVAL;
                `CSR_ADDR_MIP:        idx = `CSR_IDX_MIP;
                `CSR_ADDR_MTINST:     idx = `CSR_IDX_MTINST;
                `CSR_ADDR_MTVAL2:     idx = `CSR_IDX_MTVAL2;
                default: begin
                    // Not a machine CSR we implement.
                    idx = '0;
                    hit = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== design/csr_file.sv ====
// Machine CSR file with trap entry and interrupt detection.
// Reads are combinational with a bypass of a same-cycle write; writes
// land at the next edge. An ecall, ebreak or enabled interrupt saves the
// PC and cause and clears MIE, overriding a software write that cycle.
// msip and mtip come from the interruptor and show up in mip on read.
`include "rv_csr_consts.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_csr_pkg::csr_req_t  csr_req,
    input  rv_csr_pkg::trap_req_t trap_req,
    input  logic                  msip,
    input  logic                  mtip,
    output logic [63:0]           csr_r_data,
    output logic                  interrupt,
    output logic [63:0]           mtvec
);

    rv_csr_pkg::csr_idx_t rd_idx;
    rv_csr_pkg::csr_idx_t wr_idx;
    logic                 rd_hit;
    logic                 wr_hit;

    logic [63:0]            csr_q [`CSR_COUNT];
    logic [63:0]            csr_d [`CSR_COUNT];
    logic [`CSR_COUNT-1:0]  w_onehot;
    logic [63:0]            mip_live;
    logic [63:0]            irq_pend;
    logic                   trap_fire;
    logic [63:0]            trap_cause;

    csr_addr_decode u_rd_dec (
        .addr (csr_req.r_addr),
        .en   (csr_req.r_en),
        .idx  (rd_idx),
        .hit  (rd_hit)
    );

    csr_addr_decode u_wr_dec (
        .addr (csr_req.w_addr),
        .en   (csr_req.w_en),
        .idx  (wr_idx),
        .hit  (wr_hit)
    );

    assign w_onehot = wr_hit ? (`CSR_COUNT'(1) << wr_idx) : '0;

    // Stored mip plus the live lines from the interruptor.
    assign mip_live = csr_q[`CSR_IDX_MIP]
                    | (msip ? `MIP_MSIP : 64'd0)
                    | (mtip ? `MIP_MTIP : 64'd0);

    assign irq_pend  = csr_q[`CSR_IDX_MIE] & mip_live;
    assign interrupt = ((csr_q[`CSR_IDX_MSTATUS] & `MSTATUS_MIE) != 64'd0)
                     && (irq_pend != 64'd0);

    assign trap_fire = trap_req.ecall | trap_req.ebreak | interrupt;

    // Cause priority follows the exception order, then MSI over MTI.
    always_comb begin
        if (trap_req.ecall) begin
            trap_cause = `CAUSE_ECALL_M;
        end else if (trap_req.ebreak) begin
            trap_cause = `CAUSE_BREAKPOINT;
        end else if ((irq_pend & `MIP_MSIP) != 64'd0) begin
            trap_cause = `CAUSE_MSI;
        end else begin
            trap_cause = `CAUSE_MTI;
        end
    end

    always_comb begin
        for (int i = 0; i < `CSR_COUNT; i++) begin
            csr_d[i] = w_onehot[i] ? csr_req.w_data : csr_q[i];
        end
        if (trap_fire) begin
            csr_d[`CSR_IDX_MEPC]    = trap_req.pc;
            csr_d[`CSR_IDX_MCAUSE]  = trap_cause;
            csr_d[`CSR_IDX_MSTATUS] = csr_q[`CSR_IDX_MSTATUS] & ~`MSTATUS_MIE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CSR_COUNT; i++) begin
                csr_q[i] <= (i == `CSR_IDX_MSTATUS) ? `MSTATUS_RESET : 64'd0;
            end
        end else begin
            for (int i = 0; i < `CSR_COUNT; i++) begin
                csr_q[i] <= csr_d[i];
            end
        end
    end

    // mip always shows the live value, never the bypassed write data.
    always_comb begin
        if (!rd_hit) begin
            csr_r_data = 64'd0;
        end else if (rd_idx == `CSR_IDX_MIP) begin
            csr_r_data = mip_live;
        end else if (wr_hit && (wr_idx == rd_idx)) begin
            csr_r_data = csr_req.w_data;   // Same-cycle write wins.
        end else begin
            csr_r_data = csr_q[rd_idx];
        end
    end

    assign mtvec = csr_q[`CSR_IDX_MTVEC];

    // The core issues at most one synchronous trap per cycle.
    a_one_sync_trap : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(trap_req.ecall && trap_req.ebreak)
    );

    // Taking an interrupt clears MIE at the next edge.
    a_irq_clears_mie : assert property (
        @(posedge clk) disable iff (!arst_n)
        interrupt |=> ((csr_q[`CSR_IDX_MSTATUS] & `MSTATUS_MIE) == 64'd0)
    );

    a_rd_hit_needs_en : assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_hit |-> csr_req.r_en
    );

endmodule

// ==== design/csr_subsys.sv ====
// Top of the machine trap block.
// The core drives the CSR port and trap requests; an APB master reaches
// the interruptor, whose msip and mtip lines feed the CSR file.
module csr_subsys (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_csr_pkg::csr_req_t  csr_req,
    input  rv_csr_pkg::trap_req_t trap_req,
    input  rv_csr_pkg::apb_req_t  apb_req,
    output rv_csr_pkg::apb_rsp_t  apb_rsp,
    output logic [63:0]           csr_r_data,
    output logic                  interrupt,
    output logic [63:0]           mtvec
);

    logic msip;   // Software interrupt line.
    logic mtip;   // Timer interrupt line.

    csr_file u_csr_file (
        .clk        (clk),
        .arst_n     (arst_n),
        .csr_req    (csr_req),
        .trap_req   (trap_req),
        .msip       (msip),
        .mtip       (mtip),
        .csr_r_data (csr_r_data),
        .interrupt  (interrupt),
        .mtvec      (mtvec)
    );

    clint u_clint (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .msip    (msip),
        .mtip    (mtip)
    );

endmodule

// ==== design/rv_csr_consts.svh ====
// Constants for the machine-mode CSR block and the core-local interruptor.
// Holds CSR addresses, register indices, bit masks, trap cause codes and
// the APB register offsets of the interruptor.
// Include it in any file that needs one of these values.
`ifndef RV_CSR_CONSTS_SVH
`define RV_CSR_CONSTS_SVH

`define CSR_COUNT             15

`define CSR_ADDR_MSTATUS      12'h300 // Machine status.
`define CSR_ADDR_MISA         12'h301
`define CSR_ADDR_MEDELEG      12'h302
`define CSR_ADDR_MIDELEG      12'h303
`define CSR_ADDR_MIE          12'h304 // Interrupt enables.
`define CSR_ADDR_MTVEC        12'h305 // Trap vector base.
`define CSR_ADDR_MCOUNTEREN   12'h306
`define CSR_ADDR_MSTATUSH     12'h310
`define CSR_ADDR_MSCRATCH     12'h340
`define CSR_ADDR_MEPC         12'h341 // Trap return PC.
`define CSR_ADDR_MCAUSE       12'h342
`define CSR_ADDR_MTVAL        12'h343
`define CSR_ADDR_MIP          12'h344 // Interrupt pending.
`define CSR_ADDR_MTINST       12'h34A
`define CSR_ADDR_MTVAL2       12'h34B

`define CSR_IDX_MSTATUS       4'd0
`define CSR_IDX_MISA          4'd1
`define CSR_IDX_MEDELEG       4'd2
`define CSR_IDX_MIDELEG       4'd3
`define CSR_IDX_MIE           4'd4
`define CSR_IDX_MTVEC         4'd5
`define CSR_IDX_MCOUNTEREN    4'd6
`define CSR_IDX_MSTATUSH      4'd7
`define CSR_IDX_MSCRATCH      4'd8
`define CSR_IDX_MEPC          4'd9
`define CSR_IDX_MCAUSE        4'd10
`define CSR_IDX_MTVAL         4'd11
`define CSR_IDX_MIP           4'd12
`define CSR_IDX_MTINST        4'd13
`define CSR_IDX_MTVAL2        4'd14

`define MSTATUS_MIE           64'h0000_0000_0000_0008
`define MIP_MSIP              64'h0000_0000_0000_0008
`define MIP_MTIP              64'h0000_0000_0000_0080
`define MIE_MSIE              64'h0000_0000_0000_0008
`define MIE_MTIE              64'h0000_0000_0000_0080

`define CAUSE_ECALL_M         64'd11
`define CAUSE_BREAKPOINT      64'd3
`define CAUSE_MSI             64'h8000_0000_0000_0003 // Interrupt bit plus code 3.
`define CAUSE_MTI             64'h8000_0000_0000_0007 // Interrupt bit plus code 7.

`define MSTATUS_RESET         64'h0000_000A_0000_1800 // XLEN fields 64, MPP machine.

`define CLINT_MSIP            16'h0000
`define CLINT_MTIMECMP_LO     16'h4000
`define CLINT_MTIMECMP_HI     16'h4004
`define CLINT_MTIME_LO        16'hBFF8
`define CLINT_MTIME_HI        16'hBFFC

`endif

// ==== design/rv_csr_pkg.sv ====
// Shared types for the machine CSR block and its interruptor.
// The core-side CSR port, the trap request and the APB bus structs
// are used by the RTL and the testbench alike.
package rv_csr_pkg;

    // Register index inside the CSR array.
    typedef logic [3:0] csr_idx_t;

    // One access from the core; read and write can happen in the same cycle.
    typedef struct packed {
        logic        r_en;
        logic        w_en;
        logic [11:0] r_addr;
        logic [11:0] w_addr;
        logic [63:0] w_data;
    } csr_req_t;

    typedef struct packed {
        logic        ecall;
        logic        ebreak;
        logic [63:0] pc;     // PC of the trapping instruction.
    } trap_req_t;

    // APB master to slave.
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB slave to master.
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== test/tb_clk_gen.sv ====
// Clock and reset source for the CSR block testbench.
// Makes a clock of period 20 and holds arst_n low for five cycles.
module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;   // Release away from the active edge.
    end

endmodule

// ==== test/tb_csr_subsys.sv ====
// Testbench for the machine trap block with its interruptor.
// Drives the CSR port, trap requests and APB bus on falling edges and
// checks CSR storage, write bypass, traps, software and timer interrupts
// and APB error responses against a small model kept here.
`include "rv_csr_consts.svh"

module tb_csr_subsys;

    logic                  clk;
    logic                  arst_n;
    rv_csr_pkg::csr_req_t  csr_req;
    rv_csr_pkg::trap_req_t trap_req;
    rv_csr_pkg::apb_req_t  apb_req;
    rv_csr_pkg::apb_rsp_t  apb_rsp;
    logic [63:0]           csr_r_data;
    logic                  interrupt;
    logic [63:0]           mtvec;

    int          errors;
    logic [31:0] lcg_state;
    logic [63:0] shadow [logic [11:0]];   // Expected CSR contents by address.
    logic [63:0] exp_mtvec;
    logic [63:0] model_mtime;             // Counts every edge since reset.
    logic [63:0] mtime_at_read;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    csr_subsys u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .csr_req    (csr_req),
        .trap_req   (trap_req),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .csr_r_data (csr_r_data),
        .interrupt  (interrupt),
        .mtvec      (mtvec)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_mtime <= 64'd0;
        end else begin
            model_mtime <= model_mtime + 64'd1;
        end
    end

    // mtvec output follows the last value written to mtvec.
    a_mtvec_model : assert property (
        @(posedge clk) disable iff (!arst_n)
        mtvec == exp_mtvec
    ) else begin
        errors++;
        $display("CHECK FAILED mtvec_port expected %h actual %h",
                 $sampled(exp_mtvec), $sampled(mtvec));
    end

    // The slave never inserts wait states.
    a_pready_high : assert property (
        @(posedge clk) disable iff (!arst_n)
        apb_rsp.pready == 1'b1
    ) else begin
        errors++;
        $display("CHECK FAILED apb_pready expected 1 actual %b",
                 $sampled(apb_rsp.pready));
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s.", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [63:0] data);
        @(negedge clk);
        csr_req.w_en   = 1'b1;
        csr_req.w_addr = addr;
        csr_req.w_data = data;
        @(posedge clk);
        shadow[addr] = data;
        if (addr == `CSR_ADDR_MTVEC) begin
            exp_mtvec = data;
        end
        @(negedge clk);
        csr_req.w_en = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, input logic en, output logic [63:0] data);
        @(negedge clk);
        csr_req.r_en   = en;
        csr_req.r_addr = addr;
        #1;
        data = csr_r_data;
        csr_req.r_en = 1'b0;
    endtask

    task automatic trap_pulse(input logic ecall, input logic ebreak, input logic [63:0] pc);
        @(negedge clk);
        trap_req.ecall  = ecall;
        trap_req.ebreak = ebreak;
        trap_req.pc     = pc;
        @(negedge clk);
        trap_req.ecall  = 1'b0;
        trap_req.ebreak = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b1;
        apb_req.paddr  = addr;
        apb_req.pwdata = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b0;
        apb_req.paddr  = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        data          = apb_rsp.prdata;
        err           = apb_rsp.pslverr;
        mtime_at_read = model_mtime;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic wait_interrupt(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (interrupt !== level) begin
            if (n >= max_cycles) begin
                stop_on_timeout(level ? "interrupt to rise" : "interrupt to fall");
            end
            @(negedge clk);
            #1;
            n++;
        end
    endtask

    initial begin
        logic [11:0] store_addrs [$];
        logic [63:0] val;
        logic [63:0] pc;
        logic [31:0] rd;
        logic [31:0] cmp_lo;
        logic        err;
        int          n;
        int          offset;

        errors    = 0;
        lcg_state = 32'h3f494763;
        exp_mtvec = 64'd0;
        csr_req   = '0;
        trap_req  = '0;
        apb_req   = '0;

        n = 0;
        while (arst_n !== 1'b1) begin
            if (n >= 20) begin
                stop_on_timeout("reset release");
            end
            @(negedge clk);
            n++;
        end
        #1;
        check_eq("irq_after_reset", 64'd0, {63'd0, interrupt});

        // Read-back of plain storage CSRs.
        store_addrs = '{`CSR_ADDR_MSCRATCH, `CSR_ADDR_MTVEC, `CSR_ADDR_MIE,
                        `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MIDELEG,
                        `CSR_ADDR_MCOUNTEREN, `CSR_ADDR_MSTATUSH, `CSR_ADDR_MTVAL,
                        `CSR_ADDR_MTINST, `CSR_ADDR_MTVAL2};
        foreach (store_addrs[i]) begin
            csr_write(store_addrs[i], {next_rand(), next_rand()});
            csr_read(store_addrs[i], 1'b1, val);
            check_eq("csr_readback", shadow[store_addrs[i]], val);
        end
        csr_write(`CSR_ADDR_MIE, 64'd0);
        csr_read(12'h7C0, 1'b1, val);
        check_eq("unmapped_read", 64'd0, val);
        csr_read(`CSR_ADDR_MSCRATCH, 1'b0, val);
        check_eq("disabled_read", 64'd0, val);

        // Same-cycle write and read.
        @(negedge clk);
        csr_req.w_en   = 1'b1;
        csr_req.w_addr = `CSR_ADDR_MSCRATCH;
        csr_req.w_data = {next_rand(), next_rand()};
        csr_req.r_en   = 1'b1;
        csr_req.r_addr = `CSR_ADDR_MSCRATCH;
        #1;
        check_eq("bypass_same", csr_req.w_data, csr_r_data);
        csr_req.r_addr = `CSR_ADDR_MTVAL;
        #1;
        check_eq("bypass_other", shadow[`CSR_ADDR_MTVAL], csr_r_data);
        @(posedge clk);
        shadow[`CSR_ADDR_MSCRATCH] = csr_req.w_data;
        @(negedge clk);
        csr_req.w_en = 1'b0;
        csr_req.r_en = 1'b0;

        // ecall with MIE set, then ebreak.
        csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | `MSTATUS_MIE);
        pc = {next_rand(), next_rand()};
        trap_pulse(1'b1, 1'b0, pc);
        csr_read(`CSR_ADDR_MEPC, 1'b1, val);
        check_eq("ecall_mepc", pc, val);
        csr_read(`CSR_ADDR_MCAUSE, 1'b1, val);
        check_eq("ecall_mcause", `CAUSE_ECALL_M, val);
        csr_read(`CSR_ADDR_MSTATUS, 1'b1, val);
        check_eq("ecall_mie", 64'd0, val & `MSTATUS_MIE);
        trap_pulse(1'b0, 1'b1, {next_rand(), next_rand()});
        csr_read(`CSR_ADDR_MCAUSE, 1'b1, val);
        check_eq("ebreak_mcause", `CAUSE_BREAKPOINT, val);

        // A write to mepc in a trap cycle loses.
        pc = {next_rand(), next_rand()};
        @(negedge clk);
        trap_req.ecall = 1'b1;
        trap_req.pc    = pc;
        csr_req.w_en   = 1'b1;
        csr_req.w_addr = `CSR_ADDR_MEPC;
        csr_req.w_data = ~pc;
        @(negedge clk);
        trap_req.ecall = 1'b0;
        csr_req.w_en   = 1'b0;
        csr_read(`CSR_ADDR_MEPC, 1'b1, val);
        check_eq("trap_beats_write", pc, val);

        // Software interrupt through msip.
        pc = {next_rand(), next_rand()};
        trap_req.pc = pc;
        csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | `MSTATUS_MIE);
        csr_write(`CSR_ADDR_MIE, `MIE_MSIE);
        apb_write(`CLINT_MSIP, 32'd1);
        wait_interrupt(1'b1, 8);
        csr_req.r_en   = 1'b1;
        csr_req.r_addr = `CSR_ADDR_MIP;
        #1;
        check_eq("msi_mip", `MIP_MSIP, csr_r_data & `MIP_MSIP);
        csr_req.r_en = 1'b0;
        wait_interrupt(1'b0, 4);
        csr_read(`CSR_ADDR_MCAUSE, 1'b1, val);
        check_eq("msi_mcause", `CAUSE_MSI, val);
        csr_read(`CSR_ADDR_MEPC, 1'b1, val);
        check_eq("msi_mepc", pc, val);
        apb_write(`CLINT_MSIP, 32'd0);

        // Timer interrupt from mtimecmp.
        csr_write(`CSR_ADDR_MIE, `MIE_MTIE);
        csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | `MSTATUS_MIE);
        apb_read(`CLINT_MTIME_LO, rd, err);
        check_eq("mtime_lo", mtime_at_read[31:0], rd);
        offset = 8 + (next_rand() % 16);
        cmp_lo = rd + offset;
        apb_write(`CLINT_MTIMECMP_LO, cmp_lo);
        apb_write(`CLINT_MTIMECMP_HI, mtime_at_read[63:32]);
        wait_interrupt(1'b1, offset + 4);
        csr_req.r_en   = 1'b1;
        csr_req.r_addr = `CSR_ADDR_MIP;
        #1;
        check_eq("mti_mip", `MIP_MTIP, csr_r_data & `MIP_MTIP);
        csr_req.r_en = 1'b0;
        wait_interrupt(1'b0, 4);
        csr_read(`CSR_ADDR_MCAUSE, 1'b1, val);
        check_eq("mti_mcause", `CAUSE_MTI, val);

        // Unmapped APB offsets.
        apb_read(16'h1234, rd, err);
        check_eq("apb_err_flag", 64'd1, {63'd0, err});
        check_eq("apb_err_data", 64'd0, {32'd0, rd});
        apb_write(16'h2000, 32'hFFFF_FFFF);
        apb_read(`CLINT_MSIP, rd, err);
        check_eq("apb_msip_kept", 64'd0, {32'd0, rd});
        apb_read(`CLINT_MTIMECMP_LO, rd, err);
        check_eq("apb_cmp_kept", {32'd0, cmp_lo}, {32'd0, rd});

        repeat (2) @(negedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
